//--- dv/fetch_tests.txt
// Lines 1-16: instruction word table, one hex word each, indexed by pc[5:2]
// Then squash lines: delivery index (from 0), target pc; ffffffff ends the list
00500093
fff00113
123451b7
80000217
00208293
8000a303
7ff00393
abcde437
00000497
0040a503
40208593
ffc10613
00c586b3
fedcb737
80108793
00100073
// Squash schedule, two back to back at 17 and 18
00000003 00000340
00000009 00000104
00000011 000007c0
00000012 00000200
0000001e 00001000
ffffffff ffffffff

//--- verilog.f
+incdir+rtl
rtl/mem_msg_pkg.sv
rtl/fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/fetch_pc_gen.sv
rtl/fetch_resp_filter.sv
rtl/fetch_unit.sv
dv/clk_gen.sv
dv/fetch_assert.sv
dv/fetch_tb.sv

//--- dv/fetch_tb.sv
// ----------------------------------------------------------
// Fetch stage testbench with an in-order instruction memory
// model, the squash schedule from dv/fetch_tests.txt and a
// reference PC and epoch that decode traffic is checked against
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "fetch_cfg.svh"

module fetch_tb;

  import mem_msg_pkg::*;
  import fetch_pkg::*;

  localparam int unsigned NUM_DELIVER = 48;
  localparam int unsigned IDLE_LIMIT  = 200;
  localparam int unsigned RST_LIMIT   = 20;

  // Read waiting inside the memory model
  typedef struct packed {
    mem_resp_msg_t msg;
    logic [31:0]   due;
  } pend_resp_t;

  logic          clk;
  logic          rst;
  logic          mem_req_val;
  logic          mem_req_rdy;
  mem_req_msg_t  mem_req_msg;
  logic          mem_resp_val;
  logic          mem_resp_rdy;
  mem_resp_msg_t mem_resp_msg;
  logic          squash;
  logic [31:0]   squash_target;
  logic          d_val;
  logic          d_rdy;
  fd_msg_t       d_msg;

  // Words 0-15 hold the instruction table and squash pairs follow
  logic [31:0]   test_words [0:63];
  logic [31:0]   sq_idx [$];
  logic [31:0]   sq_tgt [$];
  pend_resp_t    resp_q [$];
  int unsigned   err_count;
  int unsigned   to_count;

  clk_gen clk_gen_i (.clk (clk), .rst (rst));

  fetch_unit fetch_unit_i (
    .clk (clk), .rst (rst),
    .mem_req_val (mem_req_val), .mem_req_rdy (mem_req_rdy), .mem_req_msg (mem_req_msg),
    .mem_resp_val (mem_resp_val), .mem_resp_rdy (mem_resp_rdy), .mem_resp_msg (mem_resp_msg),
    .squash (squash), .squash_target (squash_target),
    .d_val (d_val), .d_rdy (d_rdy), .d_msg (d_msg)
  );

  // LUI 0110111 and AUIPC 0010111 use the U immediate
  function automatic logic [31:0] expected_imm(input logic [31:0] word);
    if (word[6:0] == 7'b0110111 || word[6:0] == 7'b0010111) begin
      return {word[31:12], 12'h000};
    end
    return {{20{word[31]}}, word[31:20]};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (act === exp) else begin
      err_count++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  initial begin
    int unsigned                  idx;
    int unsigned                  cycle;
    int unsigned                  idle;
    int unsigned                  n_deliv;
    logic                         sq_pending;
    logic [31:0]                  sq_target_val;
    logic [31:0]                  exp_pc;
    logic [31:0]                  exp_inst;
    logic [`FETCH_EPOCH_BITS-1:0] exp_epoch;
    logic                         exp_drop;
    pend_resp_t                   pend;

    void'($urandom(32'h77b4));
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_msg  = '0;
    squash        = 1'b0;
    squash_target = '0;
    d_rdy         = 1'b0;
    err_count     = 0;
    to_count      = 0;

    $readmemh("dv/fetch_tests.txt", test_words);
    idx = 16;
    while (idx < 62 && !$isunknown(test_words[idx]) && test_words[idx] != 32'hffffffff) begin
      sq_idx.push_back(test_words[idx]);
      sq_tgt.push_back(test_words[idx + 1]);
      idx += 2;
    end
    assert (sq_idx.size() > 0) else begin
      err_count++;
      $display("Squash schedule in dv/fetch_tests.txt is empty or could not be read");
    end

    // Bounded wait for reset release
    idx = 0;
    while ((rst !== 1'b0) && idx < RST_LIMIT) begin
      @(posedge clk);
      idx++;
    end
    if (rst !== 1'b0) begin
      to_count++;
      $display("Timeout: reset was never released");
    end

    cycle      = 0;
    idle       = 0;
    n_deliv    = 0;
    sq_pending = 1'b0;
    exp_pc     = `FETCH_RST_ADDR;
    exp_epoch  = '0;
    while (to_count == 0 && n_deliv < NUM_DELIVER) begin
      // ------------------------------------------------------------
      // Drive 1 ns past the edge
      // ------------------------------------------------------------
      #1;
      squash = sq_pending;
      if (sq_pending) begin
        squash_target = sq_target_val;
        // Epoch moves on in the squash cycle itself
        exp_epoch     = exp_epoch + 1'b1;
      end
      sq_pending  = 1'b0;
      mem_req_rdy = ($urandom % 4) != 0;
      d_rdy       = ($urandom % 10) < 7;
      // In-order memory shows its head once the delay is up
      if (resp_q.size() > 0 && resp_q[0].due <= cycle) begin
        mem_resp_val = 1'b1;
        mem_resp_msg = resp_q[0].msg;
      end else begin
        mem_resp_val = 1'b0;
        mem_resp_msg = '0;
      end

      // ------------------------------------------------------------
      // Sample mid-cycle before the transfers land
      // ------------------------------------------------------------
      @(negedge clk);
      if (mem_req_val && mem_req_rdy) begin
        compare_value("mem_req_msg.op", 32'(MEM_READ), 32'(mem_req_msg.op));
        compare_value("mem_req_msg.len", 32'd0, {28'd0, mem_req_msg.len});
        compare_value("mem_req_msg.opaque", 32'(exp_epoch), 32'(mem_req_msg.opaque));
        pend.msg.op     = MEM_READ;
        pend.msg.opaque = mem_req_msg.opaque;
        pend.msg.addr   = mem_req_msg.addr;
        pend.msg.len    = 4'd0;
        pend.msg.data   = test_words[mem_req_msg.addr[5:2]];
        // 1 to 4 cycles of latency
        pend.due        = cycle + 1 + ($urandom % 4);
        resp_q.push_back(pend);
      end
      // Stale tag or a squash cycle means drop and consume
      exp_drop = squash || (mem_resp_msg.opaque != exp_epoch);
      compare_value("d_val", 32'(mem_resp_val && !exp_drop), 32'(d_val));
      if (mem_resp_val) begin
        compare_value("mem_resp_rdy", 32'(d_rdy || exp_drop), 32'(mem_resp_rdy));
      end
      if (mem_resp_val && mem_resp_rdy) begin
        void'(resp_q.pop_front());
      end
      if (d_val && d_rdy) begin
        exp_inst = test_words[exp_pc[5:2]];
        compare_value("d_msg.pc", exp_pc, d_msg.pc);
        compare_value("d_msg.inst", exp_inst, d_msg.inst);
        compare_value("d_msg.rd", {27'd0, exp_inst[11:7]}, {27'd0, d_msg.rd});
        compare_value("d_msg.imm", expected_imm(exp_inst), d_msg.imm);
        exp_pc = exp_pc + 32'd4;
        // Redirect right after the scheduled delivery
        if (sq_idx.size() > 0 && sq_idx[0] == n_deliv) begin
          sq_pending    = 1'b1;
          sq_target_val = sq_tgt.pop_front();
          exp_pc        = sq_target_val;
          void'(sq_idx.pop_front());
        end
        n_deliv++;
        idle = 0;
      end else begin
        idle++;
      end

      @(posedge clk);
      cycle++;
      if (idle >= IDLE_LIMIT) begin
        to_count++;
        $display("Timeout: nothing reached decode for %0d cycles after %0d words",
                 IDLE_LIMIT, n_deliv);
      end
    end

    $display("Error counts: %0d value mismatches, %0d timeouts", err_count, to_count);
    if (err_count == 0 && to_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- dv/fetch_assert.sv
// ----------------------------------------------------------
// Fetch stage port checks, bound into every fetch_unit.
// Tracks reads in flight from the memory handshakes alone
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "fetch_cfg.svh"

module fetch_assert (
  input logic clk,
  input logic rst,
  input logic mem_req_val,
  input logic mem_req_rdy,
  input logic mem_resp_val,
  input logic mem_resp_rdy,
  input logic d_val,
  input logic squash
);

  logic       req_fire;
  logic       resp_fire;
  logic [3:0] num_out;

  assign req_fire  = mem_req_val && mem_req_rdy;
  assign resp_fire = mem_resp_val && mem_resp_rdy;

  // Outstanding reads as seen at the ports
  always_ff @(posedge clk) begin
    if (rst) begin
      num_out <= '0;
    end else begin
      num_out <= num_out + {3'd0, req_fire} - {3'd0, resp_fire};
    end
  end

  // Full pipe holds off new requests
  a_in_flight_limit: assert property (@(posedge clk) disable iff (rst)
    (num_out == 4'(`FETCH_MAX_IN_FLIGHT)) |-> !mem_req_val)
    else $error("mem_req_val high with %0d reads outstanding", num_out);

  // Squash cycle never hands a word to decode
  a_no_deliver_on_squash: assert property (@(posedge clk) disable iff (rst)
    squash |-> !d_val)
    else $error("d_val high in a squash cycle");

  // Both valids quiet while in reset
  a_quiet_in_reset: assert property (@(posedge clk)
    rst |-> (!mem_req_val && !d_val))
    else $error("valid raised during reset");

endmodule

bind fetch_unit fetch_assert fetch_assert_i (
  .clk          (clk),
  .rst          (rst),
  .mem_req_val  (mem_req_val),
  .mem_req_rdy  (mem_req_rdy),
  .mem_resp_val (mem_resp_val),
  .mem_resp_rdy (mem_resp_rdy),
  .d_val        (d_val),
  .squash       (squash)
);

//--- dv/clk_gen.sv
// ----------------------------------------------------------
// Testbench clock and reset source: 8 ns clock, reset held
// for the first 3 rising edges, released 1 ns after an edge
// ----------------------------------------------------------

`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic rst
);

  // 125 MHz
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

//--- rtl/fetch_unit.sv
// ----------------------------------------------------------
// Fetch stage top: memory request and response channels on
// one side, decode channel and squash input on the other
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "fetch_cfg.svh"

module fetch_unit (
  input  logic                       clk,
  input  logic                       rst,

  // Instruction memory
  output logic                       mem_req_val,
  input  logic                       mem_req_rdy,
  output mem_msg_pkg::mem_req_msg_t  mem_req_msg,
  input  logic                       mem_resp_val,
  output logic                       mem_resp_rdy,
  input  mem_msg_pkg::mem_resp_msg_t mem_resp_msg,

  // Decode
  input  logic                       squash,
  input  logic [31:0]                squash_target,
  output logic                       d_val,
  input  logic                       d_rdy,
  output fetch_pkg::fd_msg_t         d_msg
);

  logic                         req_xfer;
  logic                         resp_xfer;
  logic [`FETCH_EPOCH_BITS-1:0] epoch;

  // ----------------------------------------------------------
  // Control, address path, response path
  // ----------------------------------------------------------

  fetch_ctrl fetch_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .mem_req_rdy (mem_req_rdy),
    .resp_xfer   (resp_xfer),
    .squash      (squash),
    .mem_req_val (mem_req_val),
    .req_xfer    (req_xfer),
    .epoch       (epoch)
  );

  fetch_pc_gen fetch_pc_gen_i (
    .clk           (clk),
    .rst           (rst),
    .req_xfer      (req_xfer),
    .squash        (squash),
    .squash_target (squash_target),
    .epoch         (epoch),
    .mem_req_msg   (mem_req_msg)
  );

  fetch_resp_filter fetch_resp_filter_i (
    .mem_resp_val (mem_resp_val),
    .mem_resp_msg (mem_resp_msg),
    .mem_resp_rdy (mem_resp_rdy),
    .epoch        (epoch),
    .squash       (squash),
    .d_rdy        (d_rdy),
    .d_val        (d_val),
    .d_msg        (d_msg),
    .resp_xfer    (resp_xfer)
  );

endmodule

//--- rtl/fetch_resp_filter.sv
// ----------------------------------------------------------
// Response filter: drops stale-epoch reads, passes the rest
// to decode with back-pressure, and predecodes rd and imm
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "fetch_cfg.svh"

module fetch_resp_filter (
  input  logic                         mem_resp_val,
  input  mem_msg_pkg::mem_resp_msg_t   mem_resp_msg,
  output logic                         mem_resp_rdy,
  input  logic [`FETCH_EPOCH_BITS-1:0] epoch,
  input  logic                         squash,
  input  logic                         d_rdy,
  output logic                         d_val,
  output fetch_pkg::fd_msg_t           d_msg,
  output logic                         resp_xfer
);

  import fetch_pkg::*;

  logic  drop;
  logic  is_utype;
  inst_u word;

  // ----------------------------------------------------------
  // Drop test and handshakes
  // ----------------------------------------------------------

  // Old path or a squash this very cycle
  assign drop = (mem_resp_msg.opaque != epoch) || squash;

  // Dropped words are consumed regardless of decode
  always_comb begin
    mem_resp_rdy = d_rdy || drop;
    d_val        = mem_resp_val && !drop;
    resp_xfer    = mem_resp_val && mem_resp_rdy;
  end

  // ----------------------------------------------------------
  // Predecode
  // ----------------------------------------------------------

  assign word = mem_resp_msg.data;

  // LUI and AUIPC carry the U immediate
  assign is_utype = (word.u.opcode == OPC_LUI) || (word.u.opcode == OPC_AUIPC);

  always_comb begin
    d_msg.pc   = mem_resp_msg.addr;
    d_msg.inst = word;
    d_msg.rd   = word.i.rd;
    if (is_utype) begin
      // Upper 20 bits, low 12 zero
      d_msg.imm = {word.u.imm, 12'd0};
    end else begin
      // Sign-extend the 12-bit field
      d_msg.imm = {{20{word.i.imm[11]}}, word.i.imm};
    end
  end

endmodule

//--- rtl/fetch_pc_gen.sv
// ----------------------------------------------------------
// Fetch address generation: keeps the next fetch address,
// applies squash redirects and builds the read request
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "fetch_cfg.svh"

module fetch_pc_gen (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         req_xfer,
  input  logic                         squash,
  input  logic [31:0]                  squash_target,
  input  logic [`FETCH_EPOCH_BITS-1:0] epoch,
  output mem_msg_pkg::mem_req_msg_t    mem_req_msg
);

  import mem_msg_pkg::*;

  logic [31:0] curr_addr;
  logic [31:0] req_addr;

  // ----------------------------------------------------------
  // Redirect mux
  // ----------------------------------------------------------

  // Squash target goes out in the same cycle
  always_comb begin
    if (squash) begin
      req_addr = squash_target;
    end else begin
      req_addr = curr_addr;
    end
  end

  // ----------------------------------------------------------
  // Address register
  // ----------------------------------------------------------

  // Advance past whatever was sent, else latch a redirect
  always_ff @(posedge clk) begin
    if (rst) begin
      curr_addr <= `FETCH_RST_ADDR;
    end else if (req_xfer) begin
      curr_addr <= req_addr + 32'd4;
    end else if (squash) begin
      curr_addr <= squash_target;
    end
  end

  // Word read, tagged with the live epoch
  always_comb begin
    mem_req_msg.op     = MEM_READ;
    mem_req_msg.opaque = epoch;
    mem_req_msg.addr   = req_addr;
    mem_req_msg.len    = 4'd0;
    mem_req_msg.data   = 32'd0;
  end

endmodule

//--- rtl/fetch_ctrl.sv
// ----------------------------------------------------------
// Fetch control: tracks reads in flight, owns the epoch tag
// and decides when a new read request may go out
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "fetch_cfg.svh"

module fetch_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         mem_req_rdy,
  input  logic                         resp_xfer,
  input  logic                         squash,
  output logic                         mem_req_val,
  output logic                         req_xfer,
  output logic [`FETCH_EPOCH_BITS-1:0] epoch
);

  // Counter must reach the limit itself, hence the +1
  localparam int unsigned CNT_W = $clog2(`FETCH_MAX_IN_FLIGHT + 1);
  localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(`FETCH_MAX_IN_FLIGHT);

  logic [CNT_W-1:0]             num_in_flight;
  logic [CNT_W-1:0]             num_in_flight_next;
  logic [`FETCH_EPOCH_BITS-1:0] epoch_q;
  logic [`FETCH_EPOCH_BITS-1:0] epoch_inc;

  // ----------------------------------------------------------
  // Request handshake
  // ----------------------------------------------------------

  // Hold off while full or still in reset
  always_comb begin
    mem_req_val = !rst && (num_in_flight < MAX_CNT);
    req_xfer    = mem_req_val && mem_req_rdy;
  end

  // ----------------------------------------------------------
  // In-flight counter
  // ----------------------------------------------------------

  // Request and response in the same cycle cancel out
  always_comb begin
    num_in_flight_next = num_in_flight;
    if (req_xfer && !resp_xfer) begin
      num_in_flight_next = num_in_flight + 1'b1;
    end else if (resp_xfer && !req_xfer) begin
      num_in_flight_next = num_in_flight - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      num_in_flight <= '0;
    end else begin
      num_in_flight <= num_in_flight_next;
    end
  end

  // ----------------------------------------------------------
  // Epoch tag
  // ----------------------------------------------------------

  // Wraps freely, only equality is ever tested
  assign epoch_inc = epoch_q + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      epoch_q <= '0;
    end else if (squash) begin
      epoch_q <= epoch_inc;
    end
  end

  // New epoch visible already in the squash cycle
  // so the redirected request and the drop test agree
  always_comb begin
    if (squash) begin
      epoch = epoch_inc;
    end else begin
      epoch = epoch_q;
    end
  end

endmodule

//--- rtl/fetch_pkg.sv
// ----------------------------------------------------------
// Fetch to decode types: the message handed to decode and
// the two views of a raw instruction word used by predecode
// ----------------------------------------------------------

package fetch_pkg;

  // ----------------------------------------------------------
  // Opcodes that take the U-format immediate
  // ----------------------------------------------------------

  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;

  // ----------------------------------------------------------
  // Instruction word views
  // ----------------------------------------------------------

  // I format, 12-bit immediate in the top bits
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_itype_t;

  // U format, upper 20 bits of the immediate
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_utype_t;

  // Same 32 bits, decoded by opcode
  // rd and opcode line up in both views
  typedef union packed {
    inst_itype_t i;
    inst_utype_t u;
  } inst_u;

  // ----------------------------------------------------------
  // Message to decode
  // ----------------------------------------------------------

  // imm is already sign-extended or shifted into place
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic [4:0]  rd;
    logic [31:0] imm;
  } fd_msg_t;

endpackage

//--- rtl/mem_msg_pkg.sv
// ----------------------------------------------------------
// Instruction memory message types, shared by the request
// and response channels of the fetch stage
// ----------------------------------------------------------

`include "fetch_cfg.svh"

package mem_msg_pkg;

  // ----------------------------------------------------------
  // Operation encoding
  // ----------------------------------------------------------

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // ----------------------------------------------------------
  // Request message
  // ----------------------------------------------------------

  // Opaque comes back untouched in the response
  // Len 0 means a full 32-bit word
  typedef struct packed {
    mem_op_e                      op;
    logic [`FETCH_EPOCH_BITS-1:0] opaque;
    logic [31:0]                  addr;
    logic [3:0]                   len;
    logic [31:0]                  data;
  } mem_req_msg_t;

  // ----------------------------------------------------------
  // Response message
  // ----------------------------------------------------------

  // Same layout as the request
  // Data holds the read word on a read
  typedef struct packed {
    mem_op_e                      op;
    logic [`FETCH_EPOCH_BITS-1:0] opaque;
    logic [31:0]                  addr;
    logic [3:0]                   len;
    logic [31:0]                  data;
  } mem_resp_msg_t;

endpackage

//--- rtl/fetch_cfg.svh
// ----------------------------------------------------------
// Fetch stage sizing macros: reset address, epoch tag width
// and the cap on outstanding memory reads. Include wherever
// these sizes are needed; the packages hold the types
// ----------------------------------------------------------

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// First address fetched once reset drops
`define FETCH_RST_ADDR 32'h200

// Epoch tag width, carried in the memory opaque field
`define FETCH_EPOCH_BITS 8

// Most reads allowed outstanding at once
`define FETCH_MAX_IN_FLIGHT 4

`endif
